// File: verilog.f
+incdir+tests
design/ooo_pkg.sv
design/dispatch_rename.sv
design/reservation_station.sv
design/issue_execute.sv
design/ooo_core_top.sv
tests/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module ooo_core_tb -Mdir obj_dir -o ooo_core_sim

./obj_dir/ooo_core_sim | tee sim.log

# Verdict comes from the log
if grep -q "Verification failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
grep -q "Verification passed" sim.log

// File: tests/ooo_ref_model.svh
// Reference model for the core testbench
// Program-order register view, bus-ordered register view and pending tag records
`ifndef OOO_REF_MODEL_SVH
`define OOO_REF_MODEL_SVH

data_t    spec_regs [NUM_REGS];   // Values as sequential execution sees them
data_t    arch_regs [NUM_REGS];   // Latest program-order writer seen on the bus
int       arch_seq  [NUM_REGS];
logic     pend      [NUM_TAGS];   // Tag expects one broadcast
data_t    exp_val   [NUM_TAGS];
reg_idx_t exp_dest  [NUM_TAGS];
int       exp_seq   [NUM_TAGS];   // Program order of the owner
int       next_seq;

// Expected result of one instruction
function automatic data_t expect_result(op_e op, data_t a, data_t b);
    case (op)
        OP_SUB:  return a - b;
        OP_XOR:  return a ^ b;
        OP_MUL:  return a * b;      // Low 32 bits only
        default: return a + b;
    endcase
endfunction

function automatic void model_reset();
    for (int r = 0; r < NUM_REGS; r++) begin
        spec_regs[r] = '0;
        arch_regs[r] = '0;
        arch_seq[r]  = -1;
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
        pend[t] = 1'b0;
    end
    next_seq = 0;
endfunction

// Accepted instruction, evaluated in program order
function automatic void record_accept(inst_pkt_t p, rob_tag_t tag);
    data_t a;
    data_t b;
    a = spec_regs[p.src_a];
    b = p.use_imm ? p.imm : spec_regs[p.src_b];
    if (pend[tag]) begin
        errors++;
        $display("Tag %0d handed out again at %0t while still pending", tag, $time);
    end
    exp_val[tag]      = expect_result(p.op, a, b);
    exp_dest[tag]     = p.dest;
    exp_seq[tag]      = next_seq;
    pend[tag]         = 1'b1;
    spec_regs[p.dest] = exp_val[tag];
    next_seq++;
endfunction

// Broadcast seen, older writers never overwrite younger ones
function automatic void retire_record(rob_tag_t tag);
    if (exp_seq[tag] > arch_seq[exp_dest[tag]]) begin
        arch_regs[exp_dest[tag]] = exp_val[tag];
        arch_seq[exp_dest[tag]]  = exp_seq[tag];
    end
    pend[tag] = 1'b0;
endfunction

// Squash drops every record, reads restart from the register file
function automatic void model_squash();
    for (int t = 0; t < NUM_TAGS; t++) begin
        pend[t] = 1'b0;
    end
    for (int r = 0; r < NUM_REGS; r++) begin
        spec_regs[r] = arch_regs[r];
    end
endfunction

function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
        if (pend[t]) n++;
    end
    return n;
endfunction

`endif

// File: tests/ooo_core_tb.sv
`timescale 1ns/1ps
// Testbench for the out-of-order core
// Clock, reset, stimulus tests, CDB comparison, watchdog and summary
module ooo_core_tb;
    import ooo_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int N_ALU        = 12;
    localparam int N_CHAIN      = 3;      // Groups of four
    localparam int N_MULB       = 6;
    localparam int N_BURST      = 20;
    localparam int N_SQ         = 8;      // Each side of the squash
    localparam int TOTAL_INSTS  = N_ALU + N_CHAIN * 4 + N_MULB + N_BURST + 2 * N_SQ;
    localparam int MAX_CYCLES   = TOTAL_INSTS * 40 + 200;
    localparam int DRAIN_CYCLES = 100;    // Longest wait for outstanding broadcasts

    logic      clock;
    logic      reset;
    logic      squash;
    logic      inst_valid;
    inst_pkt_t inst;
    logic      inst_ready;
    rob_tag_t  dispatch_tag;
    cdb_pkt_t  cdb;

    int  seed = 32'hcfb9;
    int  errors = 0;
    int  checks = 0;
    int  stall_cycles = 0;    // Cycles with inst_ready low while valid
    time last_bcast = 0;
    int  close_bcasts = 0;    // Broadcasts closer than one multiply latency

    `include "ooo_ref_model.svh"

    ooo_core_top ooo_core_top_i (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .dispatch_tag (dispatch_tag),
        .cdb          (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(string name, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_idx_t rand_reg();
        data_t r;
        r = $random(seed);
        return r[2:0];
    endfunction

    function automatic op_e rand_op(logic with_mul);
        data_t r;
        r = $random(seed);
        if (r[1:0] == 2'd3 && !with_mul) return OP_ADD;
        return op_e'(r[1:0]);
    endfunction

    // Bus is stable mid-cycle, compare on the falling edge
    always @(negedge clock) begin
        if (!reset && cdb.valid) begin
            if (last_bcast != 0 && $time - last_bcast < MUL_STAGES * CLK_PERIOD) begin
                close_bcasts++;
            end
            last_bcast = $time;
            if (!pend[cdb.tag]) begin
                errors++;
                $display("Broadcast of tag %0d at %0t matches no pending instruction",
                         cdb.tag, $time);
            end else begin
                check_value("cdb.value", cdb.value, exp_val[cdb.tag]);
                check_value("cdb.dest", data_t'(cdb.dest), data_t'(exp_dest[cdb.tag]));
                retire_record(cdb.tag);
            end
        end
    end

    // Called 2 ns after a rising edge, holds the instruction until accepted
    task automatic send_inst(op_e op, reg_idx_t dest, reg_idx_t src_a, reg_idx_t src_b,
                             logic use_imm, data_t imm);
        logic taken;
        taken        = 1'b0;
        inst.op      = op;
        inst.dest    = dest;
        inst.src_a   = src_a;
        inst.src_b   = src_b;
        inst.use_imm = use_imm;
        inst.imm     = imm;
        inst_valid   = 1'b1;
        while (!taken) begin
            @(negedge clock);
            if (inst_ready) begin
                taken = 1'b1;
                record_accept(inst, dispatch_tag);
            end else begin
                stall_cycles++;
            end
            @(posedge clock);
            #2;
        end
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_count() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        repeat (4) @(posedge clock);       // Room for a stray broadcast
        #2;
    endtask

    // One squash cycle, then the quiet cycle
    task automatic do_squash();
        squash = 1'b1;
        @(posedge clock);
        #2;
        squash = 1'b0;
        model_squash();
        @(negedge clock);
        check_value("inst_ready", data_t'(inst_ready), 32'd0);
        check_value("cdb.valid", data_t'(cdb.valid), 32'd0);
        @(posedge clock);
        #2;
    endtask

    task automatic run_alu_mix();
        for (int i = 0; i < N_ALU; i++) begin
            if (i < NUM_REGS) begin
                send_inst(OP_ADD, reg_idx_t'(i), reg_idx_t'(i), 3'd0, 1'b1, rand_word());
            end else begin
                send_inst(rand_op(1'b0), rand_reg(), rand_reg(), rand_reg(), 1'b0, '0);
            end
        end
    endtask

    // Later ALU op overtakes the multiply, dependents wait on it
    task automatic run_chains();
        for (int k = 0; k < N_CHAIN; k++) begin
            send_inst(OP_MUL, 3'd1, 3'd2, 3'd3, 1'b0, '0);
            send_inst(OP_ADD, 3'd0, 3'd4, 3'd0, 1'b1, rand_word());
            send_inst(OP_ADD, 3'd5, 3'd1, 3'd0, 1'b1, rand_word());
            send_inst(OP_XOR, 3'd2, 3'd5, 3'd0, 1'b0, '0);
        end
    endtask

    // Independent multiplies must broadcast closer than their own latency
    task automatic run_mul_pairs();
        int       close_before;
        reg_idx_t src_a;
        reg_idx_t src_b;
        close_before = close_bcasts;
        for (int i = 0; i < N_MULB; i++) begin
            src_a = rand_reg() & 3'b011;    // Sources stay clear of r6 and r7
            src_b = rand_reg() & 3'b011;
            send_inst(OP_MUL, (i % 2 == 0) ? 3'd6 : 3'd7, src_a, src_b, 1'b0, '0);
        end
        wait_drain();
        if (close_bcasts == close_before) begin
            errors++;
            $display("Back-to-back multiplies never overlapped in the pipeline");
        end
    endtask

    task automatic run_mul_burst();
        int stalls_before;
        stalls_before = stall_cycles;
        for (int i = 0; i < N_BURST; i++) begin
            send_inst(OP_MUL, rand_reg(), rand_reg(), rand_reg(), i % 3 == 0, rand_word());
        end
        if (stall_cycles == stalls_before) begin
            errors++;
            $display("inst_ready never dropped during the multiply burst");
        end
    endtask

    task automatic run_squash();
        for (int i = 0; i < N_SQ; i++) begin
            send_inst(rand_op(1'b1), rand_reg(), rand_reg(), rand_reg(), 1'b0, '0);
        end
        do_squash();
        for (int i = 0; i < N_SQ; i++) begin
            send_inst(rand_op(1'b0), rand_reg(), rand_reg(), rand_reg(), 1'b0, '0);
        end
    endtask

    initial begin
        reset      = 1'b1;
        squash     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        model_reset();
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        run_alu_mix();
        wait_drain();
        run_chains();
        wait_drain();
        run_mul_pairs();
        run_mul_burst();
        wait_drain();
        run_squash();
        wait_drain();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pend[t]) begin
                errors++;
                $display("Tag %0d was recorded but never broadcast", t);
            end
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog sized from the instruction count
    initial begin
        repeat (MAX_CYCLES) @(posedge clock);
        $display("Timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: design/ooo_core_top.sv
`timescale 1ns/1ps
// Core top: rename, reservation station and execute joined by wires
module ooo_core_top (
    input  logic               clock,
    input  logic               reset,
    input  logic               squash,
    input  logic               inst_valid,
    input  ooo_pkg::inst_pkt_t inst,
    output logic               inst_ready,
    output ooo_pkg::rob_tag_t  dispatch_tag,
    output ooo_pkg::cdb_pkt_t  cdb
);
    import ooo_pkg::*;

    logic                         dp_valid;
    dp_pkt_t                      dp_pkt;
    logic [1:0]                   class_free;   // Indexed by fu_e
    logic [NUM_SLOTS-1:0]         ready_mask;
    logic [NUM_SLOTS-1:0]         issue_grant;
    issue_pkt_t [NUM_SLOTS-1:0]   slot_pkts;

    dispatch_rename dispatch_rename_i (
        .clock        (clock),
        .reset        (reset),
        .squash       (squash),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .dispatch_tag (dispatch_tag),
        .class_free   (class_free),
        .dp_valid     (dp_valid),
        .dp_pkt       (dp_pkt),
        .cdb          (cdb)
    );

    reservation_station reservation_station_i (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .dp_valid    (dp_valid),
        .dp_pkt      (dp_pkt),
        .class_free  (class_free),
        .cdb         (cdb),
        .issue_grant (issue_grant),
        .ready_mask  (ready_mask),
        .slot_pkts   (slot_pkts)
    );

    issue_execute issue_execute_i (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .ready_mask  (ready_mask),
        .slot_pkts   (slot_pkts),
        .issue_grant (issue_grant),
        .cdb         (cdb)           // Registered bus, also the core output
    );

endmodule

// File: design/issue_execute.sv
`timescale 1ns/1ps
// Issue select, one-cycle ALU, pipelined multiplier and CDB arbitration
module issue_execute (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        squash,
    input  logic [ooo_pkg::NUM_SLOTS-1:0]               ready_mask,
    input  ooo_pkg::issue_pkt_t [ooo_pkg::NUM_SLOTS-1:0] slot_pkts,
    output logic [ooo_pkg::NUM_SLOTS-1:0]               issue_grant,
    output ooo_pkg::cdb_pkt_t                           cdb
);
    import ooo_pkg::*;

    cdb_pkt_t             mul_pipe [MUL_STAGES-1];   // CDB register acts as last stage
    cdb_pkt_t             mul_out;
    logic [NUM_SLOTS-1:0] alu_pick;
    logic [NUM_SLOTS-1:0] mul_pick;
    slot_idx_t            alu_sel;
    slot_idx_t            mul_sel;
    logic                 alu_go;
    logic                 mul_go;
    issue_pkt_t           alu_in;
    issue_pkt_t           mul_in;
    data_t                alu_res;

    // Lowest ready slot of each class
    always_comb begin
        alu_pick = '0;
        mul_pick = '0;
        alu_sel  = '0;
        mul_sel  = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (ready_mask[i] && SLOT_FU[i] == FU_ALU) begin
                alu_pick = NUM_SLOTS'(1) << i;
                alu_sel  = slot_idx_t'(i);
            end
            if (ready_mask[i] && SLOT_FU[i] == FU_MULT) begin
                mul_pick = NUM_SLOTS'(1) << i;
                mul_sel  = slot_idx_t'(i);
            end
        end
    end

    assign mul_out     = mul_pipe[MUL_STAGES-2];
    assign mul_go      = (|mul_pick) && !squash;
    assign alu_go      = (|alu_pick) && !squash && !mul_out.valid;  // Bus busy with a multiply
    assign issue_grant = (alu_go ? alu_pick : '0) | (mul_go ? mul_pick : '0);
    assign alu_in      = slot_pkts[alu_sel];
    assign mul_in      = slot_pkts[mul_sel];

    always_comb begin
        case (alu_in.op)
            OP_SUB:  alu_res = alu_in.v1 - alu_in.v2;
            OP_XOR:  alu_res = alu_in.v1 ^ alu_in.v2;
            default: alu_res = alu_in.v1 + alu_in.v2;   // ADD, MUL never in an ALU slot
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < MUL_STAGES - 1; s++) begin
                mul_pipe[s] <= '0;
            end
            cdb <= '0;
        end else if (squash) begin
            for (int s = 0; s < MUL_STAGES - 1; s++) begin
                mul_pipe[s] <= '0;                   // Flush in-flight multiplies
            end
            cdb <= '0;
        end else begin
            mul_pipe[0].valid <= mul_go;
            mul_pipe[0].tag   <= mul_in.tag;
            mul_pipe[0].dest  <= mul_in.dest;
            mul_pipe[0].value <= mul_in.v1 * mul_in.v2;   // Low 32 bits
            for (int s = 1; s < MUL_STAGES - 1; s++) begin
                mul_pipe[s] <= mul_pipe[s-1];
            end
            // Multiplier has priority on the bus
            if (mul_out.valid) begin
                cdb <= mul_out;
            end else if (alu_go) begin
                cdb.valid <= 1'b1;
                cdb.tag   <= alu_in.tag;
                cdb.dest  <= alu_in.dest;
                cdb.value <= alu_res;
            end else begin
                cdb.valid <= 1'b0;
            end
        end
    end

endmodule

// File: design/reservation_station.sv
`timescale 1ns/1ps
// Reservation station with class-bound slots, CDB wakeup and free on broadcast
module reservation_station (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        squash,
    input  logic                                        dp_valid,
    input  ooo_pkg::dp_pkt_t                            dp_pkt,
    output logic [1:0]                                  class_free,
    input  ooo_pkg::cdb_pkt_t                           cdb,
    input  logic [ooo_pkg::NUM_SLOTS-1:0]               issue_grant,
    output logic [ooo_pkg::NUM_SLOTS-1:0]               ready_mask,
    output ooo_pkg::issue_pkt_t [ooo_pkg::NUM_SLOTS-1:0] slot_pkts
);
    import ooo_pkg::*;

    dp_pkt_t              slot_q [NUM_SLOTS];   // Payload plus live operand tags
    logic [NUM_SLOTS-1:0] busy;
    logic [NUM_SLOTS-1:0] issued;               // Sent to execute, awaiting broadcast
    logic [NUM_SLOTS-1:0] free_hit;
    logic                 alloc_found;
    logic                 alloc_en;
    slot_idx_t            alloc_slot;

    // Free slots per class, lowest matching slot wins
    always_comb begin
        class_free  = '0;
        alloc_found = 1'b0;
        alloc_slot  = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                class_free[SLOT_FU[i]] = 1'b1;
                if (SLOT_FU[i] == dp_pkt.fu) begin
                    alloc_found = 1'b1;
                    alloc_slot  = slot_idx_t'(i);
                end
            end
        end
    end

    assign alloc_en = dp_valid && alloc_found;   // Dispatch checked class_free already

    // Slot retires when its own tag is broadcast
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            free_hit[i] = busy[i] && cdb.valid && (cdb.tag == slot_q[i].tag);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
        end else if (squash) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (free_hit[i]) begin
                    busy[i]   <= 1'b0;
                    issued[i] <= 1'b0;
                end else if (issue_grant[i]) begin
                    issued[i] <= 1'b1;               // Drops out of ready_mask
                end
            end
            if (alloc_en) begin
                busy[alloc_slot]   <= 1'b1;          // Slot was idle, no clash with free
                issued[alloc_slot] <= 1'b0;
            end
        end
    end

    // Operand capture off the bus, then new entry write
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (cdb_hit(cdb, slot_q[i].t1)) begin
                slot_q[i].t1 <= NO_TAG;
                slot_q[i].v1 <= cdb.value;
            end
            if (cdb_hit(cdb, slot_q[i].t2)) begin
                slot_q[i].t2 <= NO_TAG;
                slot_q[i].v2 <= cdb.value;
            end
        end
        if (alloc_en) begin
            slot_q[alloc_slot] <= dp_pkt;            // Bus hits already folded in
        end
    end

    // Ready view for the issue select
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ready_mask[i] = busy[i] && !issued[i]
                         && (slot_q[i].t1 == NO_TAG) && (slot_q[i].t2 == NO_TAG);
            slot_pkts[i].op   = slot_q[i].op;
            slot_pkts[i].tag  = slot_q[i].tag;
            slot_pkts[i].dest = slot_q[i].dest;
            slot_pkts[i].v1   = slot_q[i].v1;
            slot_pkts[i].v2   = slot_q[i].v2;
        end
    end

endmodule

// File: design/dispatch_rename.sv
`timescale 1ns/1ps
// Rename stage: register file, map table, tag free list
// Builds the dispatch packet with same-cycle CDB forwarding
module dispatch_rename (
    input  logic               clock,
    input  logic               reset,
    input  logic               squash,
    input  logic               inst_valid,
    input  ooo_pkg::inst_pkt_t inst,
    output logic               inst_ready,
    output ooo_pkg::rob_tag_t  dispatch_tag,
    input  logic [1:0]         class_free,     // One bit per FU class
    output logic               dp_valid,
    output ooo_pkg::dp_pkt_t   dp_pkt,
    input  ooo_pkg::cdb_pkt_t  cdb
);
    import ooo_pkg::*;

    data_t               regfile [NUM_REGS];
    rob_tag_t            map_tbl [NUM_REGS];      // NO_TAG means regfile is current
    reg_idx_t            tag_dest [NUM_TAGS];
    logic [NUM_TAGS-1:0] older_than [NUM_TAGS];   // Row t: tags in flight when t dispatched
    logic [NUM_TAGS-1:0] tag_busy;
    logic [NUM_TAGS-1:0] stale;                   // Younger writer already updated the reg
    logic [NUM_TAGS-1:0] cdb_mask;
    logic                hold;                    // Quiet cycle after reset or squash
    logic                tag_found;
    logic                accept;
    logic                cdb_wr;
    rob_tag_t            free_tag;
    rob_tag_t            ta;
    rob_tag_t            tb;
    fu_e                 inst_fu;

    // Lowest free tag, tag 0 never handed out
    always_comb begin
        tag_found = 1'b0;
        free_tag  = NO_TAG;
        for (int i = NUM_TAGS - 1; i >= 1; i--) begin
            if (!tag_busy[i]) begin
                tag_found = 1'b1;
                free_tag  = rob_tag_t'(i);
            end
        end
    end

    assign inst_fu      = (inst.op == OP_MUL) ? FU_MULT : FU_ALU;
    assign inst_ready   = tag_found && class_free[inst_fu] && !squash && !hold;
    assign accept       = inst_valid && inst_ready;
    assign dispatch_tag = free_tag;
    assign dp_valid     = accept;
    assign cdb_wr       = cdb.valid && !stale[cdb.tag];   // Only the newest result lands
    assign cdb_mask     = cdb.valid ? (NUM_TAGS'(1) << cdb.tag) : '0;

    // Source lookup, map first, then regfile or bus
    always_comb begin
        ta          = map_tbl[inst.src_a];
        tb          = map_tbl[inst.src_b];
        dp_pkt.op   = inst.op;
        dp_pkt.fu   = inst_fu;
        dp_pkt.tag  = free_tag;
        dp_pkt.dest = inst.dest;
        dp_pkt.t1   = ta;
        dp_pkt.v1   = regfile[inst.src_a];
        dp_pkt.t2   = tb;
        dp_pkt.v2   = regfile[inst.src_b];
        if (cdb_hit(cdb, ta)) begin
            dp_pkt.t1 = NO_TAG;                      // Producer broadcasting right now
            dp_pkt.v1 = cdb.value;
        end
        if (inst.use_imm) begin
            dp_pkt.t2 = NO_TAG;
            dp_pkt.v2 = inst.imm;
        end else if (cdb_hit(cdb, tb)) begin
            dp_pkt.t2 = NO_TAG;
            dp_pkt.v2 = cdb.value;
        end
    end

    // Map table, free list and write ordering
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                map_tbl[r] <= NO_TAG;
            end
            for (int t = 0; t < NUM_TAGS; t++) begin
                older_than[t] <= '0;
            end
            tag_busy <= '0;
            stale    <= '0;
            hold     <= 1'b1;
        end else if (squash) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                map_tbl[r] <= NO_TAG;
            end
            tag_busy <= '0;                          // Everything in flight is dropped
            hold     <= 1'b1;
        end else begin
            hold <= 1'b0;
            if (cdb.valid) begin
                tag_busy[cdb.tag] <= 1'b0;
                if (map_tbl[cdb.dest] == cdb.tag) begin
                    map_tbl[cdb.dest] <= NO_TAG;     // Still the latest writer
                end
            end
            // Older writers of the same reg must not overwrite this result
            if (cdb_wr) begin
                for (int u = 1; u < NUM_TAGS; u++) begin
                    if (older_than[cdb.tag][u] && tag_dest[u] == cdb.dest) begin
                        stale[u] <= 1'b1;
                    end
                end
            end
            if (accept) begin
                tag_busy[free_tag]   <= 1'b1;
                stale[free_tag]      <= 1'b0;
                map_tbl[inst.dest]   <= free_tag;    // Sources already read the old entry
                for (int t = 0; t < NUM_TAGS; t++) begin
                    older_than[t][free_tag] <= 1'b0; // New tag is younger than all
                end
                older_than[free_tag] <= tag_busy & ~cdb_mask;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            tag_dest[free_tag] <= inst.dest;
        end
    end

    // Architectural registers survive a squash
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regfile[r] <= '0;
            end
        end else if (cdb_wr) begin
            regfile[cdb.dest] <= cdb.value;
        end
    end

endmodule

// File: design/ooo_pkg.sv
// Shared widths, opcodes, slot class map and packet structs
// Also holds the CDB tag match helper used by rename and the station
package ooo_pkg;

    localparam int NUM_REGS   = 8;
    localparam int NUM_TAGS   = 16;           // Tag 0 reserved as "value ready"
    localparam int NUM_SLOTS  = 6;
    localparam int MUL_STAGES = 3;            // Issue to CDB latency of a multiply

    typedef logic [31:0] data_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [3:0]  rob_tag_t;
    typedef logic [2:0]  slot_idx_t;

    localparam rob_tag_t NO_TAG = '0;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_e;

    // Class of each station slot, fixed at build time
    localparam fu_e SLOT_FU [NUM_SLOTS] = '{FU_ALU, FU_ALU, FU_ALU, FU_ALU, FU_MULT, FU_MULT};

    // Instruction as it arrives from outside
    typedef struct packed {
        op_e      op;
        reg_idx_t dest;
        reg_idx_t src_a;
        reg_idx_t src_b;
        logic     use_imm;     // imm stands in for src_b
        data_t    imm;
    } inst_pkt_t;

    // Renamed instruction, dispatch to station
    typedef struct packed {
        op_e      op;
        fu_e      fu;
        rob_tag_t tag;         // Result tag
        reg_idx_t dest;
        rob_tag_t t1;          // Zero when v1 holds the value
        data_t    v1;
        rob_tag_t t2;
        data_t    v2;
    } dp_pkt_t;

    // Common data bus broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest;
        data_t    value;
    } cdb_pkt_t;

    // Slot contents seen by execute
    typedef struct packed {
        op_e      op;
        rob_tag_t tag;
        reg_idx_t dest;
        data_t    v1;
        data_t    v2;
    } issue_pkt_t;

    // Pending operand tag matches this cycle's broadcast
    function automatic logic cdb_hit(cdb_pkt_t c, rob_tag_t t);
        return c.valid && (t != NO_TAG) && (c.tag == t);
    endfunction

endpackage
